// ==== verilog/exu_consts.svh ====
`ifndef EXU_CONSTS_SVH
`define EXU_CONSTS_SVH

// data and address width, fixed by RV64I
`define EXU_XLEN 64

// low half used by the word forms
`define EXU_WORD_W 32

// shift amounts, doubleword and word forms
`define EXU_SHAMT_W 6
`define EXU_SHAMTW_W 5

// register file index
`define EXU_REG_IDX_W 5

// encoding widths
`define EXU_GRP_W 2
`define EXU_ALU_OP_W 4
`define EXU_BJP_OP_W 3
`define EXU_LS_SIZE_W 2

`endif

// ==== verilog/exu_pkg.sv ====
`include "exu_consts.svh"

package exu_pkg;

  // instruction group from decode
  typedef enum logic [`EXU_GRP_W-1:0] {
    GRP_ALU = 2'd0,
    GRP_BJP = 2'd1,
    GRP_LS  = 2'd2,
    GRP_BAD = 2'd3
  } exu_grp_e;

  // alu operation, codes 11..15 unused
  typedef enum logic [`EXU_ALU_OP_W-1:0] {
    ADD  = 4'd0,
    SUB  = 4'd1,
    SLL  = 4'd2,
    SLT  = 4'd3,
    SLTU = 4'd4,
    XOR  = 4'd5,
    SRL  = 4'd6,
    SRA  = 4'd7,
    OR   = 4'd8,
    AND  = 4'd9,
    LUI  = 4'd10
  } alu_op_e;

  // branch and jump operation
  typedef enum logic [`EXU_BJP_OP_W-1:0] {
    JAL  = 3'd0,
    JALR = 3'd1,
    BEQ  = 3'd2,
    BNE  = 3'd3,
    BLT  = 3'd4,
    BGE  = 3'd5,
    BLTU = 3'd6,
    BGEU = 3'd7
  } bjp_op_e;

  typedef enum logic {
    LOAD  = 1'b0,
    STORE = 1'b1
  } ls_dir_e;

  typedef enum logic [`EXU_LS_SIZE_W-1:0] {
    BYTE  = 2'd0,
    HALF  = 2'd1,
    WORD  = 2'd2,
    DWORD = 2'd3
  } ls_size_e;

endpackage

// ==== verilog/exu_alu_if.sv ====
`timescale 1ns/1ns
`include "exu_consts.svh"

interface exu_alu_if;
  import exu_pkg::*;

  // request side
  alu_op_e              alu_op;
  logic                 word_op;
  logic [`EXU_XLEN-1:0] opa;
  logic [`EXU_XLEN-1:0] opb;

  // result and flags of opa - opb
  logic [`EXU_XLEN-1:0] result;
  logic                 eq;
  logic                 lt;
  logic                 ltu;

  modport ctrl (
    output alu_op, word_op, opa, opb,
    input  result, eq, lt, ltu
  );

  modport alu (
    input  alu_op, word_op, opa, opb,
    output result, eq, lt, ltu
  );

endinterface

// ==== verilog/exu_alu.sv ====
`timescale 1ns/1ns
`include "exu_consts.svh"

module exu_alu (
  exu_alu_if.alu alu
);
  import exu_pkg::*;

  logic                     sub_en;
  logic [`EXU_XLEN:0]       sum;
  logic [`EXU_SHAMT_W-1:0]  shamt;
  logic [`EXU_SHAMTW_W-1:0] shamt_w;
  logic [`EXU_WORD_W-1:0]   opa_lo;
  logic [`EXU_XLEN-1:0]     sll_res;
  logic [`EXU_XLEN-1:0]     srl_res;
  logic [`EXU_XLEN-1:0]     sra_res;
  logic [`EXU_WORD_W-1:0]   word_res;
  logic [`EXU_XLEN-1:0]     dword_res;
  logic                     word_sel;

  // adder subtracts for everything except ADD, so the flags hold on a compare
  assign sub_en = (alu.alu_op != ADD);

  assign sum = {1'b0, alu.opa}
             + {1'b0, (sub_en ? ~alu.opb : alu.opb)}
             + {{`EXU_XLEN{1'b0}}, sub_en};

  // carry out clear means borrow
  assign alu.ltu = ~sum[`EXU_XLEN];
  assign alu.lt  = (alu.opa[`EXU_XLEN-1] & ~alu.opb[`EXU_XLEN-1])
                 | (~(alu.opa[`EXU_XLEN-1] ^ alu.opb[`EXU_XLEN-1]) & sum[`EXU_XLEN-1]);
  assign alu.eq  = (alu.opa == alu.opb);

  assign shamt   = alu.opb[`EXU_SHAMT_W-1:0];
  assign shamt_w = alu.opb[`EXU_SHAMTW_W-1:0];
  assign opa_lo  = alu.opa[`EXU_WORD_W-1:0];

  assign sll_res = alu.opa << shamt;
  assign srl_res = alu.opa >> shamt;
  assign sra_res = $signed(alu.opa) >>> shamt;

  // doubleword forms
  always_comb begin
    case (alu.alu_op)
      ADD:     dword_res = sum[`EXU_XLEN-1:0];
      SUB:     dword_res = sum[`EXU_XLEN-1:0];
      SLL:     dword_res = sll_res;
      SLT:     dword_res = {{(`EXU_XLEN-1){1'b0}}, alu.lt};
      SLTU:    dword_res = {{(`EXU_XLEN-1){1'b0}}, alu.ltu};
      XOR:     dword_res = alu.opa ^ alu.opb;
      SRL:     dword_res = srl_res;
      SRA:     dword_res = sra_res;
      OR:      dword_res = alu.opa | alu.opb;
      AND:     dword_res = alu.opa & alu.opb;
      LUI:     dword_res = alu.opb;
      default: dword_res = '0;
    endcase
  end

  // word forms, low half of opa with a five-bit amount
  always_comb begin
    word_sel = alu.word_op;
    case (alu.alu_op)
      ADD:     word_res = sum[`EXU_WORD_W-1:0];
      SUB:     word_res = sum[`EXU_WORD_W-1:0];
      SLL:     word_res = opa_lo << shamt_w;
      SRL:     word_res = opa_lo >> shamt_w;
      SRA:     word_res = $signed(opa_lo) >>> shamt_w;
      default: begin
        // no word form, fall back to the doubleword result
        word_res = '0;
        word_sel = 1'b0;
      end
    endcase
  end

  assign alu.result = word_sel ?
                      {{(`EXU_XLEN-`EXU_WORD_W){word_res[`EXU_WORD_W-1]}}, word_res} :
                      dword_res;

endmodule

// ==== verilog/exu_bjp.sv ====
`timescale 1ns/1ns
`include "exu_consts.svh"

module exu_bjp (
  input  exu_pkg::bjp_op_e     bjp_op_i,
  input  logic                 en_i,
  input  logic                 eq_i,
  input  logic                 lt_i,
  input  logic                 ltu_i,
  input  logic [`EXU_XLEN-1:0] base_i,
  input  logic [`EXU_XLEN-1:0] offset_i,
  output logic                 taken_o,
  output logic [`EXU_XLEN-1:0] target_o
);
  import exu_pkg::*;

  logic cond;

  // condition from the alu compare flags
  always_comb begin
    case (bjp_op_i)
      JAL:     cond = 1'b1;
      JALR:    cond = 1'b1;
      BEQ:     cond = eq_i;
      BNE:     cond = ~eq_i;
      BLT:     cond = lt_i;
      BGE:     cond = ~lt_i;
      BLTU:    cond = ltu_i;
      BGEU:    cond = ~ltu_i;
      default: cond = 1'b0;
    endcase
  end

  assign taken_o = en_i & cond;

  // separate adder, the alu is busy with the return address or compare
  assign target_o = base_i + offset_i;

endmodule

// ==== verilog/exu.sv ====
`timescale 1ns/1ns
`include "exu_consts.svh"

module exu (
  input  logic                      clk,
  input  logic                      rst_i,
  input  logic                      valid_i,
  input  exu_pkg::exu_grp_e         grp_i,
  input  exu_pkg::alu_op_e          alu_op_i,
  input  exu_pkg::bjp_op_e          bjp_op_i,
  input  exu_pkg::ls_dir_e          ls_dir_i,
  input  exu_pkg::ls_size_e         ls_size_i,
  input  logic                      ls_unsigned_i,
  input  logic                      word_op_i,
  input  logic [`EXU_XLEN-1:0]      opa_i,
  input  logic [`EXU_XLEN-1:0]      opb_i,
  input  logic [`EXU_XLEN-1:0]      aux_a_i,
  input  logic [`EXU_XLEN-1:0]      aux_b_i,
  input  logic [`EXU_REG_IDX_W-1:0] rd_idx_i,
  input  logic                      rd_wr_en_i,
  output logic                      valid_o,
  output logic                      rd_wr_en_o,
  output logic [`EXU_REG_IDX_W-1:0] rd_idx_o,
  output logic [`EXU_XLEN-1:0]      result_o,
  output logic                      jump_o,
  output logic [`EXU_XLEN-1:0]      jump_addr_o,
  output logic                      ls_valid_o,
  output exu_pkg::ls_dir_e          ls_dir_o,
  output exu_pkg::ls_size_e         ls_size_o,
  output logic                      ls_unsigned_o,
  output logic [`EXU_XLEN-1:0]      store_data_o,
  output logic                      illegal_o,
  exu_alu_if.ctrl                   alu
);
  import exu_pkg::*;

  logic                 is_alu;
  logic                 is_bjp;
  logic                 is_ls;
  logic                 is_bad;
  logic                 is_jump;
  logic                 is_branch;
  logic                 taken;
  logic [`EXU_XLEN-1:0] target;

  // group decode
  assign is_alu    = (grp_i == GRP_ALU);
  assign is_bjp    = (grp_i == GRP_BJP);
  assign is_ls     = (grp_i == GRP_LS);
  assign is_bad    = (grp_i == GRP_BAD);
  assign is_jump   = is_bjp & ((bjp_op_i == JAL) | (bjp_op_i == JALR));
  assign is_branch = is_bjp & ~is_jump;

  // steer onto the alu: add for address and link, sub for compare
  always_comb begin
    if (is_alu) begin
      alu.alu_op = alu_op_i;
    end else if (is_branch) begin
      alu.alu_op = SUB;
    end else begin
      alu.alu_op = ADD;
    end
  end

  assign alu.word_op = is_alu & word_op_i;
  assign alu.opa     = opa_i;
  assign alu.opb     = opb_i;

  exu_bjp u_bjp (
    .bjp_op_i (bjp_op_i),
    .en_i     (is_bjp),
    .eq_i     (alu.eq),
    .lt_i     (alu.lt),
    .ltu_i    (alu.ltu),
    .base_i   (aux_a_i),
    .offset_i (aux_b_i),
    .taken_o  (taken),
    .target_o (target)
  );

  // qualifiers, low after reset and on idle cycles
  always_ff @(posedge clk) begin
    if (rst_i) begin
      valid_o    <= 1'b0;
      rd_wr_en_o <= 1'b0;
      jump_o     <= 1'b0;
      ls_valid_o <= 1'b0;
      illegal_o  <= 1'b0;
    end else begin
      valid_o    <= valid_i;
      rd_wr_en_o <= valid_i & rd_wr_en_i & ~is_branch & ~is_bad;
      jump_o     <= valid_i & taken;
      ls_valid_o <= valid_i & is_ls;
      illegal_o  <= valid_i & is_bad;
    end
  end

  // payload, held on idle cycles
  always_ff @(posedge clk) begin
    if (valid_i) begin
      rd_idx_o      <= rd_idx_i;
      result_o      <= (is_branch | is_bad) ? '0 : alu.result;
      jump_addr_o   <= is_bjp ? target : '0;
      ls_dir_o      <= is_ls ? ls_dir_i : LOAD;
      ls_size_o     <= is_ls ? ls_size_i : BYTE;
      ls_unsigned_o <= is_ls & ls_unsigned_i;
      store_data_o  <= (is_ls && ls_dir_i == STORE) ? aux_b_i : '0;
    end
  end

endmodule

// ==== verilog/ex_stage_top.sv ====
`timescale 1ns/1ns
`include "exu_consts.svh"

module ex_stage_top (
  input  logic                      clk,
  input  logic                      rst_i,
  input  logic                      valid_i,
  input  exu_pkg::exu_grp_e         grp_i,
  input  exu_pkg::alu_op_e          alu_op_i,
  input  exu_pkg::bjp_op_e          bjp_op_i,
  input  exu_pkg::ls_dir_e          ls_dir_i,
  input  exu_pkg::ls_size_e         ls_size_i,
  input  logic                      ls_unsigned_i,
  input  logic                      word_op_i,
  input  logic [`EXU_XLEN-1:0]      opa_i,
  input  logic [`EXU_XLEN-1:0]      opb_i,
  input  logic [`EXU_XLEN-1:0]      aux_a_i,
  input  logic [`EXU_XLEN-1:0]      aux_b_i,
  input  logic [`EXU_REG_IDX_W-1:0] rd_idx_i,
  input  logic                      rd_wr_en_i,
  output logic                      valid_o,
  output logic                      rd_wr_en_o,
  output logic [`EXU_REG_IDX_W-1:0] rd_idx_o,
  output logic [`EXU_XLEN-1:0]      result_o,
  output logic                      jump_o,
  output logic [`EXU_XLEN-1:0]      jump_addr_o,
  output logic                      ls_valid_o,
  output exu_pkg::ls_dir_e          ls_dir_o,
  output exu_pkg::ls_size_e         ls_size_o,
  output logic                      ls_unsigned_o,
  output logic [`EXU_XLEN-1:0]      store_data_o,
  output logic                      illegal_o
);

  exu_alu_if u_alu_if ();

  // combinational alu
  exu_alu u_alu (
    .alu (u_alu_if.alu)
  );

  // decode, steering and output register
  exu u_exu (
    .clk           (clk),
    .rst_i         (rst_i),
    .valid_i       (valid_i),
    .grp_i         (grp_i),
    .alu_op_i      (alu_op_i),
    .bjp_op_i      (bjp_op_i),
    .ls_dir_i      (ls_dir_i),
    .ls_size_i     (ls_size_i),
    .ls_unsigned_i (ls_unsigned_i),
    .word_op_i     (word_op_i),
    .opa_i         (opa_i),
    .opb_i         (opb_i),
    .aux_a_i       (aux_a_i),
    .aux_b_i       (aux_b_i),
    .rd_idx_i      (rd_idx_i),
    .rd_wr_en_i    (rd_wr_en_i),
    .valid_o       (valid_o),
    .rd_wr_en_o    (rd_wr_en_o),
    .rd_idx_o      (rd_idx_o),
    .result_o      (result_o),
    .jump_o        (jump_o),
    .jump_addr_o   (jump_addr_o),
    .ls_valid_o    (ls_valid_o),
    .ls_dir_o      (ls_dir_o),
    .ls_size_o     (ls_size_o),
    .ls_unsigned_o (ls_unsigned_o),
    .store_data_o  (store_data_o),
    .illegal_o     (illegal_o),
    .alu           (u_alu_if.ctrl)
  );

endmodule

// ==== verif/tb_ex_stage.sv ====
`timescale 1ns/1ns
`include "exu_consts.svh"

module tb_ex_stage;
  import exu_pkg::*;

  localparam int SEED           = 73337;
  localparam int NUM_INSTR      = 2000;
  localparam int RST_CYCLES     = 16;
  localparam int TIMEOUT_CYCLES = 3000 + RST_CYCLES;

  // one expected output set per clock
  typedef struct packed {
    logic                      valid;
    logic                      rd_wr_en;
    logic [`EXU_REG_IDX_W-1:0] rd_idx;
    logic [`EXU_XLEN-1:0]      result;
    logic                      jump;
    logic [`EXU_XLEN-1:0]      jump_addr;
    logic                      ls_valid;
    logic                      ls_dir;
    logic [1:0]                ls_size;
    logic                      ls_unsigned;
    logic [`EXU_XLEN-1:0]      store_data;
    logic                      illegal;
  } exp_t;

  logic clk;
  logic rst_i;
  logic valid_i;
  exu_grp_e grp_i;
  alu_op_e alu_op_i;
  bjp_op_e bjp_op_i;
  ls_dir_e ls_dir_i;
  ls_size_e ls_size_i;
  logic ls_unsigned_i;
  logic word_op_i;
  logic [`EXU_XLEN-1:0] opa_i;
  logic [`EXU_XLEN-1:0] opb_i;
  logic [`EXU_XLEN-1:0] aux_a_i;
  logic [`EXU_XLEN-1:0] aux_b_i;
  logic [`EXU_REG_IDX_W-1:0] rd_idx_i;
  logic rd_wr_en_i;

  logic valid_o;
  logic rd_wr_en_o;
  logic [`EXU_REG_IDX_W-1:0] rd_idx_o;
  logic [`EXU_XLEN-1:0] result_o;
  logic jump_o;
  logic [`EXU_XLEN-1:0] jump_addr_o;
  logic ls_valid_o;
  ls_dir_e ls_dir_o;
  ls_size_e ls_size_o;
  logic ls_unsigned_o;
  logic [`EXU_XLEN-1:0] store_data_o;
  logic illegal_o;

  exp_t exp_q[$];
  exp_t last_exp = '0;
  int   cycle_cnt = 0;
  int   issued;

  ex_stage_top uut (.*);

  always #20 clk = ~clk;

  // run limit
  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test failed");
      $fatal(1, "timeout");
    end
  end

  // reference alu, straight from the instruction rules
  function automatic logic [`EXU_XLEN-1:0] alu_model(input alu_op_e op, input logic word,
                                                      input logic [`EXU_XLEN-1:0] a,
                                                      input logic [`EXU_XLEN-1:0] b);
    logic [`EXU_XLEN-1:0] r;
    logic [31:0]          w;
    logic                 has_word;
    case (op)
      ADD:     r = a + b;
      SUB:     r = a - b;
      SLL:     r = a << b[5:0];
      SLT:     r = {63'b0, $signed(a) < $signed(b)};
      SLTU:    r = {63'b0, a < b};
      XOR:     r = a ^ b;
      SRL:     r = a >> b[5:0];
      SRA:     r = $signed(a) >>> b[5:0];
      OR:      r = a | b;
      AND:     r = a & b;
      LUI:     r = b;
      default: r = '0;
    endcase
    has_word = (op == ADD) || (op == SUB) || (op == SLL) || (op == SRL) || (op == SRA);
    if (word && has_word) begin
      case (op)
        ADD:     w = a[31:0] + b[31:0];
        SUB:     w = a[31:0] - b[31:0];
        SLL:     w = a[31:0] << b[4:0];
        SRL:     w = a[31:0] >> b[4:0];
        default: w = $signed(a[31:0]) >>> b[4:0];
      endcase
      r = {{32{w[31]}}, w};
    end
    return r;
  endfunction

  function automatic logic branch_model(input bjp_op_e op, input logic [`EXU_XLEN-1:0] a,
                                        input logic [`EXU_XLEN-1:0] b);
    case (op)
      BEQ:     return a == b;
      BNE:     return a != b;
      BLT:     return $signed(a) < $signed(b);
      BGE:     return $signed(a) >= $signed(b);
      BLTU:    return a < b;
      BGEU:    return a >= b;
      default: return 1'b1;
    endcase
  endfunction

  function automatic exp_t expected_outputs();
    exp_t e;
    e = '0;
    e.valid  = valid_i;
    e.rd_idx = rd_idx_i;
    if (valid_i) begin
      case (grp_i)
        GRP_ALU: begin
          e.result   = alu_model(alu_op_i, word_op_i, opa_i, opb_i);
          e.rd_wr_en = rd_wr_en_i;
        end
        GRP_BJP: begin
          e.jump_addr = aux_a_i + aux_b_i;
          e.jump      = branch_model(bjp_op_i, opa_i, opb_i);
          if (bjp_op_i == JAL || bjp_op_i == JALR) begin
            e.result   = opa_i + opb_i;
            e.rd_wr_en = rd_wr_en_i;
          end
        end
        GRP_LS: begin
          e.result      = opa_i + opb_i;
          e.rd_wr_en    = rd_wr_en_i;
          e.ls_valid    = 1'b1;
          e.ls_dir      = ls_dir_i;
          e.ls_size     = ls_size_i;
          e.ls_unsigned = ls_unsigned_i;
          e.store_data  = (ls_dir_i == STORE) ? aux_b_i : '0;
        end
        default: e.illegal = 1'b1;
      endcase
    end
    return e;
  endfunction

  // zero, sign boundaries and all ones show up often
  function automatic logic [`EXU_XLEN-1:0] pick_operand();
    case ($urandom % 8)
      0:       return '0;
      1:       return 64'h8000_0000_0000_0000;
      2:       return 64'h7fff_ffff_ffff_ffff;
      3:       return '1;
      4:       return 64'h0000_0000_8000_0000;
      5:       return 64'h0000_0000_7fff_ffff;
      default: return {$urandom, $urandom};
    endcase
  endfunction

  task automatic drive_inputs(input bit allow_issue);
    valid_i       = allow_issue && (($urandom % 4) != 0);
    grp_i         = exu_grp_e'($urandom % 4);
    alu_op_i      = alu_op_e'($urandom % 11);
    bjp_op_i      = bjp_op_e'($urandom % 8);
    ls_dir_i      = ls_dir_e'($urandom % 2);
    ls_size_i     = ls_size_e'($urandom % 4);
    ls_unsigned_i = $urandom % 2;
    word_op_i     = $urandom % 2;
    rd_wr_en_i    = $urandom % 2;
    rd_idx_i      = $urandom % 32;
    opa_i         = pick_operand();
    opb_i         = (($urandom % 4) == 0) ? opa_i : pick_operand();
    aux_a_i       = {$urandom, $urandom};
    aux_b_i       = pick_operand();
    exp_q.push_back(expected_outputs());
  endtask

  task automatic check_value(input string name, input logic [`EXU_XLEN-1:0] got,
                             input logic [`EXU_XLEN-1:0] exp);
    assert (got === exp) else begin
      $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
      $display("Test failed");
      $fatal(1, "output check failed");
    end
  endtask

  task automatic check_outputs();
    exp_t e;
    e = exp_q.pop_front();
    check_value("valid_o", valid_o, e.valid);
    check_value("rd_wr_en_o", rd_wr_en_o, e.rd_wr_en);
    check_value("jump_o", jump_o, e.jump);
    check_value("ls_valid_o", ls_valid_o, e.ls_valid);
    check_value("illegal_o", illegal_o, e.illegal);
    // data outputs hold the last strobe's values on idle cycles
    if (e.valid) begin
      last_exp = e;
    end
    if (last_exp.valid) begin
      check_value("rd_idx_o", rd_idx_o, last_exp.rd_idx);
      check_value("result_o", result_o, last_exp.result);
      check_value("jump_addr_o", jump_addr_o, last_exp.jump_addr);
      check_value("ls_dir_o", ls_dir_o, last_exp.ls_dir);
      check_value("ls_size_o", ls_size_o, last_exp.ls_size);
      check_value("ls_unsigned_o", ls_unsigned_o, last_exp.ls_unsigned);
      check_value("store_data_o", store_data_o, last_exp.store_data);
    end
  endtask

  initial begin
    clk = 1'b0;
    rst_i = 1'b1;
    void'($urandom(SEED));
    drive_inputs(1'b0);
    exp_q.delete();
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    // qualifiers cleared by reset
    check_value("valid_o", valid_o, '0);
    check_value("rd_wr_en_o", rd_wr_en_o, '0);
    check_value("jump_o", jump_o, '0);
    check_value("ls_valid_o", ls_valid_o, '0);
    check_value("illegal_o", illegal_o, '0);
    rst_i = 1'b0;
    issued = 0;
    while (issued < NUM_INSTR) begin
      drive_inputs(1'b1);
      if (valid_i) begin
        issued = issued + 1;
      end
      @(negedge clk);
      check_outputs();
    end
    // trailing idle cycle drops the qualifiers
    drive_inputs(1'b0);
    @(negedge clk);
    check_outputs();
    $display("Test completed successfully");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+verilog
verilog/exu_pkg.sv
verilog/exu_alu_if.sv
verilog/exu_alu.sv
verilog/exu_bjp.sv
verilog/exu.sv
verilog/ex_stage_top.sv
verif/tb_ex_stage.sv

// ==== Bender.yml ====
package:
  name: ex_stage

sources:
  - target: rtl
    include_dirs:
      - verilog
    files:
      - verilog/exu_pkg.sv
      - verilog/exu_alu_if.sv
      - verilog/exu_alu.sv
      - verilog/exu_bjp.sv
      - verilog/exu.sv
      - verilog/ex_stage_top.sv

  - target: test
    include_dirs:
      - verilog
    files:
      - verif/tb_ex_stage.sv
